// File: project.f
+incdir+testbench
verilog/udp_echo_pkg.sv
verilog/frame_decode.sv
verilog/reply_build.sv
verilog/reply_emit.sv
verilog/udp_echo_top.sv
testbench/tb_udp_echo.sv

// File: Bender.yml
package:
  name: udp_echo

sources:
  - files:
      - verilog/udp_echo_pkg.sv
      - verilog/frame_decode.sv
      - verilog/reply_build.sv
      - verilog/reply_emit.sv
      - verilog/udp_echo_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_udp_echo.sv

// File: testbench/tb_frame_util.svh
// frame builder and reply model for the echo testbench
// kind 0 matches, kinds 1 to 4 break one field each
`ifndef TB_FRAME_UTIL_SVH
`define TB_FRAME_UTIL_SVH

// big-endian field into the frame being built
task automatic put_bytes(input int pos, input int n, input logic [47:0] val);
    for (int k = 0; k < n; k++) begin
        frame_q[pos + k] = val[8 * (n - 1 - k) +: 8];
    end
endtask

// kind 1 wrong port, 2 wrong IP, 3 TCP, 4 IPv6 ethertype
task automatic build_frame(input int kind, input int pay_len);
    frame_q.delete();
    for (int k = 0; k < HDR_LEN + pay_len; k++) begin
        frame_q.push_back(8'(rand_bits(8)));
    end
    put_bytes(0, 6, LOCAL_MAC);
    put_bytes(12, 2, (kind == 4) ? 16'h86DD : 16'h0800);
    put_bytes(14, 1, 8'h45);
    put_bytes(16, 2, 28 + pay_len);
    put_bytes(23, 1, (kind == 3) ? 8'd6 : 8'd17);
    put_bytes(30, 4, (kind == 2) ? LOCAL_IP + 32'd1 : LOCAL_IP);
    put_bytes(36, 2, (kind == 1) ? ECHO_PORT + 16'd1 : ECHO_PORT);
    put_bytes(38, 2, 8 + pay_len);
endtask

// reply bytes for the frame in frame_q queued for the checker
task automatic expect_reply();
    logic [7:0]  r [HDR_LEN];
    logic [31:0] sum;
    for (int i = 0; i < HDR_LEN; i++) begin
        r[i] = 8'h00;
    end
    for (int i = 0; i < 6; i++) begin
        r[i]     = frame_q[6 + i];
        r[6 + i] = LOCAL_MAC[8 * (5 - i) +: 8];
    end
    r[12] = 8'h08;
    r[14] = 8'h45;
    r[16] = frame_q[16];
    r[17] = frame_q[17];
    r[22] = REPLY_TTL;
    r[23] = 8'd17;
    for (int i = 0; i < 4; i++) begin
        r[26 + i] = LOCAL_IP[8 * (3 - i) +: 8];
        r[30 + i] = frame_q[26 + i];
    end
    // ports swap and the UDP length stays
    r[34] = frame_q[36];
    r[35] = frame_q[37];
    r[36] = frame_q[34];
    r[37] = frame_q[35];
    r[38] = frame_q[38];
    r[39] = frame_q[39];
    sum = '0;
    for (int i = 14; i < 34; i += 2) begin
        sum = sum + {16'd0, r[i], r[i + 1]};
    end
    while (sum[31:16] != 16'd0) begin
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    end
    r[24] = ~sum[15:8];
    r[25] = ~sum[7:0];
    for (int i = 0; i < HDR_LEN; i++) begin
        exp_q.push_back(r[i]);
        last_q.push_back(1'b0);
    end
    for (int i = HDR_LEN; i < frame_q.size(); i++) begin
        exp_q.push_back(frame_q[i]);
        last_q.push_back(i == frame_q.size() - 1);
    end
    led_q.push_back(frame_q[HDR_LEN]);
    replies_exp++;
endtask

`endif

// File: testbench/tb_udp_echo.sv
// testbench for the UDP echo responder
// LFSR stimulus, reply model queues, byte checker and report
`timescale 1ns/1ps

module tb_udp_echo;

    localparam logic [47:0] LOCAL_MAC  = 48'h02_00_00_00_00_00;
    localparam logic [31:0] LOCAL_IP   = {8'd172, 8'd28, 8'd0, 8'd128};
    localparam logic [15:0] ECHO_PORT  = 16'd1234;
    localparam logic [7:0]  REPLY_TTL  = 8'd64;
    localparam int          HDR_LEN    = 42;
    localparam int          WAIT_LIMIT = 2000;

    logic       clk;
    logic       rst;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_last;
    logic       in_ready;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_last;
    logic       out_ready;
    logic [7:0] led;

    // model queues in output order
    logic [7:0]  frame_q[$];
    logic [7:0]  exp_q[$];
    logic        last_q[$];
    logic [7:0]  led_q[$];
    logic [31:0] lfsr;
    int          replies_exp;
    int          replies_done;
    int          errors;
    int          err_mark;
    int          tests;
    int          tests_failed;
    bit          gap_en;
    bit          stall_en;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("run stopped, %s", why);
        $display("** FAIL **");
        $finish;
    endtask

    // falling edge where all inputs change
    task automatic tick();
        @(negedge clk);
        out_ready = stall_en ? (rand_bits(2) != 32'd0) : 1'b1;
    endtask

    `include "tb_frame_util.svh"

    udp_echo_top #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .ECHO_PORT (ECHO_PORT),
        .REPLY_TTL (REPLY_TTL)
    ) u_udp_echo_top (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready),
        .led       (led)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // byte checker sampling the values held before each rising edge
    initial begin : byte_check
        logic [7:0] exp_b;
        logic       exp_l;
        logic [7:0] led_exp;
        bit         led_pending;
        led_pending = 1'b0;
        forever begin
            @(posedge clk);
            if (led_pending) begin
                assert (led == led_exp) else begin
                    $display("[FAIL] %0t: led %h, expected %h", $time, led, led_exp);
                    errors++;
                end
                led_pending = 1'b0;
                replies_done++;
            end
            if (!rst && out_valid && out_ready) begin
                assert (exp_q.size() > 0) else begin
                    $display("[FAIL] %0t: output byte %h with no reply due", $time, out_data);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    exp_b = exp_q.pop_front();
                    exp_l = last_q.pop_front();
                    assert (out_data == exp_b && out_last == exp_l) else begin
                        $display("[FAIL] %0t: out %h last %b, expected %h last %b",
                                 $time, out_data, out_last, exp_b, exp_l);
                        errors++;
                    end
                    if (exp_l) begin
                        led_exp     = led_q.pop_front();
                        led_pending = 1'b1;
                    end
                end
            end
        end
    end

    task automatic send_frame();
        int  gap;
        int  t;
        bit  done;
        for (int i = 0; i < frame_q.size(); i++) begin
            gap = gap_en ? int'(rand_bits(2)) : 0;
            in_valid = 1'b0;
            repeat (gap) tick();
            in_data  = frame_q[i];
            in_valid = 1'b1;
            in_last  = (i == frame_q.size() - 1);
            t    = 0;
            done = 1'b0;
            while (!done) begin
                @(posedge clk);
                done = in_ready;
                tick();
                t++;
                if (!done && t > WAIT_LIMIT) begin
                    abort_run("in_ready stayed low while a byte was offered");
                end
            end
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    // waits for every queued reply and then reports the test
    task automatic close_test(input string name);
        int t;
        t = 0;
        while (replies_done != replies_exp) begin
            tick();
            t++;
            if (t > WAIT_LIMIT) begin
                abort_run($sformatf("%s never finished reply %0d", name, replies_done + 1));
            end
        end
        assert (!out_valid) else begin
            $display("[FAIL] %0t: output still valid after the last reply", $time);
            errors++;
        end
        tests++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("test %0d %-26s %s, %0d errors", tests, name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
        err_mark = errors;
    endtask

    initial begin : stimulus
        int n;
        lfsr         = 32'h3868_7219;
        rst          = 1'b1;
        in_data      = '0;
        in_valid     = 1'b0;
        in_last      = 1'b0;
        out_ready    = 1'b1;
        gap_en       = 1'b0;
        stall_en     = 1'b0;
        replies_exp  = 0;
        replies_done = 0;
        errors       = 0;
        err_mark     = 0;
        tests        = 0;
        tests_failed = 0;
        repeat (5) tick();
        rst = 1'b0;

        for (int k = 0; k < 4; k++) begin
            build_frame(0, 1 + rand_bits(5));
            expect_reply();
            send_frame();
        end
        close_test("matching frames");

        // each dropped kind is followed by a good frame
        for (int k = 1; k <= 4; k++) begin
            build_frame(k, 1 + rand_bits(5));
            send_frame();
            build_frame(0, 1 + rand_bits(5));
            expect_reply();
            send_frame();
        end
        close_test("non-matching frames");

        for (int k = 0; k < 4; k++) begin
            build_frame(0, 8);
            n = (k == 0) ? HDR_LEN : 1 + int'(rand_bits(6) % HDR_LEN);
            frame_q = frame_q[0:n-1];
            send_frame();
        end
        build_frame(0, 1 + rand_bits(5));
        expect_reply();
        send_frame();
        close_test("short frames");

        gap_en = 1'b1;
        for (int k = 0; k < 4; k++) begin
            build_frame(0, k[0] ? 1 : 1 + rand_bits(5));
            expect_reply();
            send_frame();
        end
        close_test("led");

        gap_en   = 1'b0;
        stall_en = 1'b1;
        for (int k = 0; k < 8; k++) begin
            build_frame(0, 1 + rand_bits(5));
            expect_reply();
            send_frame();
        end
        close_test("back-to-back with stalls");
        stall_en = 1'b0;

        $display("%0d tests, %0d failed, %0d replies checked, %0d errors",
                 tests, tests_failed, replies_done, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog/udp_echo_top.sv
// UDP echo responder top level
// decode, build and emit stages on an 8-bit valid/ready stream
`timescale 1ns/1ps

module udp_echo_top #(
    parameter logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_00,
    parameter logic [31:0] LOCAL_IP  = {8'd172, 8'd28, 8'd0, 8'd128},
    parameter logic [15:0] ECHO_PORT = 16'd1234,
    parameter logic [7:0]  REPLY_TTL = 8'd64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    input  logic       in_last,
    output logic       in_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    input  logic       out_ready,
    output logic [7:0] led
);
    import udp_echo_pkg::*;

    // received header
    logic       hdr_valid;
    logic       hdr_ready;
    pkt_hdr_u   hdr;

    // rewritten header with checksum
    logic       reply_valid;
    logic       reply_ready;
    pkt_hdr_u   reply;

    // payload of the frame being echoed
    logic [7:0] pay_data;
    logic       pay_valid;
    logic       pay_last;
    logic       pay_ready;

    frame_decode #(
        .LOCAL_IP  (LOCAL_IP),
        .ECHO_PORT (ECHO_PORT)
    ) u_frame_decode (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .hdr_valid (hdr_valid),
        .hdr       (hdr),
        .hdr_ready (hdr_ready),
        .pay_data  (pay_data),
        .pay_valid (pay_valid),
        .pay_last  (pay_last),
        .pay_ready (pay_ready)
    );

    reply_build #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .REPLY_TTL (REPLY_TTL)
    ) u_reply_build (
        .clk         (clk),
        .rst         (rst),
        .hdr_valid   (hdr_valid),
        .hdr         (hdr),
        .hdr_ready   (hdr_ready),
        .reply_valid (reply_valid),
        .reply       (reply),
        .reply_ready (reply_ready)
    );

    reply_emit u_reply_emit (
        .clk         (clk),
        .rst         (rst),
        .reply_valid (reply_valid),
        .reply       (reply),
        .reply_ready (reply_ready),
        .pay_data    (pay_data),
        .pay_valid   (pay_valid),
        .pay_last    (pay_last),
        .pay_ready   (pay_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_last    (out_last),
        .out_ready   (out_ready),
        .led         (led)
    );

endmodule

// File: verilog/reply_emit.sv
// reply serializer sending the header bytes and then the echoed payload
// also keeps the first payload byte of each reply on the LEDs
`timescale 1ns/1ps

module reply_emit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   reply_valid,
    input  udp_echo_pkg::pkt_hdr_u reply,
    output logic                   reply_ready,
    input  logic [7:0]             pay_data,
    input  logic                   pay_valid,
    input  logic                   pay_last,
    output logic                   pay_ready,
    output logic [7:0]             out_data,
    output logic                   out_valid,
    output logic                   out_last,
    input  logic                   out_ready,
    output logic [7:0]             led
);
    import udp_echo_pkg::*;

    localparam logic [1:0] E_IDLE = 2'd0;
    localparam logic [1:0] E_HDR  = 2'd1;
    localparam logic [1:0] E_PAY  = 2'd2;

    logic [1:0] phase;
    logic [5:0] cnt;
    logic       first;
    pkt_hdr_u   rep;
    logic       out_xfer;

    assign reply_ready = phase == E_IDLE;

    // payload moves straight through once the header is out
    assign pay_ready = (phase == E_PAY) && out_ready;
    assign out_valid = (phase == E_HDR) || ((phase == E_PAY) && pay_valid);
    assign out_data  = (phase == E_HDR) ? rep.bytes[cnt] : pay_data;
    assign out_last  = (phase == E_PAY) && pay_last;
    assign out_xfer  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= E_IDLE;
            cnt   <= '0;
            first <= 1'b0;
            led   <= '0;
        end else begin
            case (phase)
                E_IDLE: begin
                    if (reply_valid) begin
                        phase <= E_HDR;
                        cnt   <= '0;
                    end
                end
                E_HDR: begin
                    if (out_xfer) begin
                        if (cnt == 6'(HDR_BYTES - 1)) begin
                            phase <= E_PAY;
                            first <= 1'b1;
                        end else begin
                            cnt <= cnt + 6'd1;
                        end
                    end
                end
                default: begin
                    if (out_xfer) begin
                        if (first) begin
                            led   <= pay_data;
                            first <= 1'b0;
                        end
                        if (pay_last) begin
                            phase <= E_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // local copy so the builder can take the next header
    always_ff @(posedge clk) begin
        if (reply_valid && reply_ready) begin
            rep <= reply;
        end
    end

    out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: verilog/reply_build.sv
// reply header rewrite and sequential IPv4 header checksum
`timescale 1ns/1ps

module reply_build #(
    parameter logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_00,
    parameter logic [31:0] LOCAL_IP  = {8'd172, 8'd28, 8'd0, 8'd128},
    parameter logic [7:0]  REPLY_TTL = 8'd64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hdr_valid,
    input  udp_echo_pkg::pkt_hdr_u hdr,
    output logic                   hdr_ready,
    output logic                   reply_valid,
    output udp_echo_pkg::pkt_hdr_u reply,
    input  logic                   reply_ready
);
    import udp_echo_pkg::*;

    logic        busy;
    logic [3:0]  cnt;
    logic [19:0] acc;
    logic [15:0] word;
    logic        hdr_xfer;
    logic        sum_done;

    // only one reply in flight
    assign hdr_ready = !busy && !reply_valid;
    assign hdr_xfer  = hdr_valid && hdr_ready;
    assign sum_done  = cnt == 4'(IP_HDR_WORDS);

    // current IPv4 header word with the checksum field still zero
    assign word = {reply.bytes[IP_OFFSET + 2 * cnt], reply.bytes[IP_OFFSET + 2 * cnt + 1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            cnt         <= '0;
            reply_valid <= 1'b0;
        end else begin
            if (reply_valid && reply_ready) begin
                reply_valid <= 1'b0;
            end
            if (hdr_xfer) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (sum_done) begin
                    busy        <= 1'b0;
                    reply_valid <= 1'b1;
                end else begin
                    cnt <= cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            reply.f.dst_mac    <= hdr.f.src_mac;
            reply.f.src_mac    <= LOCAL_MAC;
            reply.f.ethertype  <= ETHERTYPE_IPV4;
            reply.f.ver_ihl    <= IP_VER_IHL;
            reply.f.tos        <= '0;
            reply.f.total_len  <= hdr.f.total_len;
            reply.f.ident      <= '0;
            reply.f.flags_frag <= '0;
            reply.f.ttl        <= REPLY_TTL;
            reply.f.protocol   <= IP_PROTO_UDP;
            reply.f.hdr_csum   <= '0;
            reply.f.src_ip     <= LOCAL_IP;
            reply.f.dst_ip     <= hdr.f.src_ip;
            reply.f.src_port   <= hdr.f.dst_port;
            reply.f.dst_port   <= hdr.f.src_port;
            reply.f.udp_len    <= hdr.f.udp_len;
            reply.f.udp_csum   <= '0;
            acc                <= '0;
        end else if (busy) begin
            if (sum_done) begin
                reply.f.hdr_csum <= ~csum_fold(acc);
            end else begin
                acc <= acc + {4'd0, word};
            end
        end
    end

    // ten sum cycles and the fold cycle before the sampled rise
    csum_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(reply_valid) |-> $past(hdr_valid && hdr_ready, 12));

endmodule

// File: verilog/frame_decode.sv
// header capture and match check for incoming frames
// forwards the payload of matching frames and discards the rest
`timescale 1ns/1ps

module frame_decode #(
    parameter logic [31:0] LOCAL_IP  = {8'd172, 8'd28, 8'd0, 8'd128},
    parameter logic [15:0] ECHO_PORT = 16'd1234
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             in_data,
    input  logic                   in_valid,
    input  logic                   in_last,
    output logic                   in_ready,
    output logic                   hdr_valid,
    output udp_echo_pkg::pkt_hdr_u hdr,
    input  logic                   hdr_ready,
    output logic [7:0]             pay_data,
    output logic                   pay_valid,
    output logic                   pay_last,
    input  logic                   pay_ready
);
    import udp_echo_pkg::*;

    localparam logic [1:0] S_INIT = 2'd0;
    localparam logic [1:0] S_HDR  = 2'd1;
    localparam logic [1:0] S_PAY  = 2'd2;
    localparam logic [1:0] S_DROP = 2'd3;

    logic [1:0] state;
    logic [5:0] cnt;
    logic       in_xfer;
    logic       hdr_done;
    logic       match;

    assign in_xfer  = in_valid && in_ready;
    assign hdr_done = cnt == 6'(HDR_BYTES - 1);

    // every checked field sits before the last header byte
    assign match = hdr.f.ethertype == ETHERTYPE_IPV4
                && hdr.f.ver_ihl == IP_VER_IHL
                && hdr.f.protocol == IP_PROTO_UDP
                && hdr.f.dst_ip == LOCAL_IP
                && hdr.f.dst_port == ECHO_PORT;

    always_comb begin
        case (state)
            // hold off a new header while the last one is still offered
            S_HDR:   in_ready = !hdr_valid;
            S_PAY:   in_ready = pay_ready;
            S_DROP:  in_ready = 1'b1;
            default: in_ready = 1'b0;
        endcase
    end

    assign pay_data  = in_data;
    assign pay_valid = in_valid && (state == S_PAY);
    assign pay_last  = in_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_INIT;
            cnt       <= '0;
            hdr_valid <= 1'b0;
        end else begin
            if (hdr_valid && hdr_ready) begin
                hdr_valid <= 1'b0;
            end
            case (state)
                S_INIT: state <= S_HDR;
                S_HDR: begin
                    if (in_xfer) begin
                        if (in_last) begin
                            // short frame or empty payload
                            cnt <= '0;
                        end else if (hdr_done) begin
                            cnt <= '0;
                            if (match) begin
                                hdr_valid <= 1'b1;
                                state     <= S_PAY;
                            end else begin
                                state <= S_DROP;
                            end
                        end else begin
                            cnt <= cnt + 6'd1;
                        end
                    end
                end
                default: begin
                    if (in_xfer && in_last) begin
                        state <= S_HDR;
                    end
                end
            endcase
        end
    end

    // header bytes land straight in the byte view
    always_ff @(posedge clk) begin
        if (state == S_HDR && in_xfer) begin
            hdr.bytes[cnt] <= in_data;
        end
    end

    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr));

endmodule

// File: verilog/udp_echo_pkg.sv
// header layout of the Ethernet/IPv4/UDP frame, byte and field views
// protocol constants and the checksum fold helper
package udp_echo_pkg;

    // Ethernet 14 + IPv4 20 + UDP 8
    localparam int HDR_BYTES = 42;

    // IPv4 header position inside the frame header
    localparam int IP_OFFSET    = 14;
    localparam int IP_HDR_WORDS = 10;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    // version 4, five-word header, no options
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;

    // first field is the first on the wire
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_csum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } pkt_hdr_t;

    // bytes[0] lines up with dst_mac[47:40]
    typedef union packed {
        logic [0:HDR_BYTES-1][7:0] bytes;
        pkt_hdr_t                  f;
    } pkt_hdr_u;

    // folds a sum of up to sixteen 16-bit words
    // into a ones'-complement 16-bit value
    function automatic logic [15:0] csum_fold(input logic [19:0] sum);
        logic [16:0] s1;
        s1 = {1'b0, sum[15:0]} + {13'd0, sum[19:16]};
        // second pass catches the carry of the first
        return s1[15:0] + {15'd0, s1[16]};
    endfunction

endpackage
